/* source/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

        localparam int xlen = 32;
        localparam int num_regs = 32;
        localparam int apb_addr_w = 12;

        typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

        // apb byte addresses
        localparam logic [apb_addr_w-1:0] addr_instr = 12'h000;
        localparam logic [apb_addr_w-1:0] addr_status = 12'h004;
        localparam logic [apb_addr_w-1:0] addr_retired = 12'h008;
        localparam logic [apb_addr_w-1:0] addr_reg_base = 12'h080;
        localparam logic [apb_addr_w-1:0] addr_reg_last = 12'h0fc; // x31

        // status word bits
        localparam int status_illegal_bit = 0; // sticky until a 1 is written
        localparam int status_zero_bit = 1;

        // major opcodes handled here
        typedef enum logic [6:0] {
                opc_op     = 7'b0110011,
                opc_op_imm = 7'b0010011,
                opc_lui    = 7'b0110111
        } rv_opcode_e;

        typedef enum logic [3:0] {
                alu_add    = 4'd0,
                alu_sub    = 4'd1,
                alu_sll    = 4'd2,
                alu_slt    = 4'd3,
                alu_sltu   = 4'd4,
                alu_xor    = 4'd5,
                alu_srl    = 4'd6,
                alu_sra    = 4'd7,
                alu_or     = 4'd8,
                alu_and    = 4'd9,
                alu_pass_b = 4'd10 // lui
        } alu_op_e;

endpackage

`default_nettype wire

/* source/exec_if.sv */
`default_nettype none

interface exec_if import rv_exec_pkg::*; ();

        logic valid;    // legal instruction this cycle
        logic illegal;  // bad encoding this cycle
        alu_op_e op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [xlen-1:0] imm;
        logic use_imm;  // operand b from imm

        modport producer (
                output valid, illegal, op, rd, rs1, rs2, imm, use_imm
        );

        modport consumer (
                input valid, illegal, op, rd, rs1, rs2, imm, use_imm
        );

endinterface

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu import rv_exec_pkg::*; (
        exec_if.consumer ex,
        input logic [xlen-1:0] rs1_data,
        input logic [xlen-1:0] rs2_data,
        output logic [xlen-1:0] result,
        output logic zero
);

        logic [xlen-1:0] b;
        logic [$clog2(xlen)-1:0] shamt;
        logic lt_signed;
        logic lt_unsigned;

        assign b = ex.use_imm ? ex.imm : rs2_data;
        assign shamt = b[$clog2(xlen)-1:0]; // low 5 bits only

        assign lt_signed = $signed(rs1_data) < $signed(b);
        assign lt_unsigned = rs1_data < b;

        always_comb begin
                case (ex.op)
                alu_add:
                        result = rs1_data + b;
                alu_sub:
                        result = rs1_data - b;
                alu_sll:
                        result = rs1_data << shamt;
                alu_slt:
                        result = {{(xlen-1){1'b0}}, lt_signed};
                alu_sltu:
                        result = {{(xlen-1){1'b0}}, lt_unsigned};
                alu_xor:
                        result = rs1_data ^ b;
                alu_srl:
                        result = rs1_data >> shamt;
                alu_sra:
                        result = $signed(rs1_data) >>> shamt; // sign fill
                alu_or:
                        result = rs1_data | b;
                alu_and:
                        result = rs1_data & b;
                alu_pass_b:
                        result = b;
                default:
                        result = '0;
                endcase
        end

        assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file import rv_exec_pkg::*; (
        input logic clk,
        input logic reset,
        exec_if.consumer ex,
        input logic [xlen-1:0] wdata,
        input reg_idx_t dbg_addr,
        input logic dbg_we,
        input logic [xlen-1:0] dbg_wdata,
        output logic [xlen-1:0] rs1_data,
        output logic [xlen-1:0] rs2_data,
        output logic [xlen-1:0] dbg_rdata
);

        logic [xlen-1:0] regs [num_regs];
        logic ex_we;
        logic dbg_we_ok;

        assign ex_we = ex.valid && (ex.rd != '0);
        assign dbg_we_ok = dbg_we && (dbg_addr != '0);

        // entry 0 is cleared at reset and never written
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < num_regs; i++)
                                regs[i] <= '0;
                end else begin
                        if (ex_we)
                                regs[ex.rd] <= wdata;
                        if (dbg_we_ok)
                                regs[dbg_addr] <= dbg_wdata;
                end
        end

        assign rs1_data = regs[ex.rs1];
        assign rs2_data = regs[ex.rs2];
        assign dbg_rdata = regs[dbg_addr];

        // host access is held off by the apb setup cycle
        a_single_writer: assert property (
                @(posedge clk) disable iff (reset) !(ex.valid && dbg_we)
        );

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`default_nettype none

module rv_decoder import rv_exec_pkg::*; (
        input logic clk,
        input logic reset,
        input logic [xlen-1:0] instr,
        input logic instr_valid,
        exec_if.producer ex
);

        rv_opcode_e opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        alu_op_e op;
        logic legal;
        logic use_imm;
        logic [xlen-1:0] imm;

        assign opcode = rv_opcode_e'(instr[6:0]);
        assign funct3 = instr[14:12];
        assign funct7 = instr[31:25];

        always_comb begin
                op = alu_add;
                legal = 1'b0;
                use_imm = 1'b0;
                imm = {{(xlen-12){instr[31]}}, instr[31:20]}; // i-immediate
                case (opcode)
                opc_op: begin
                        legal = 1'b1;
                        case ({funct7, funct3})
                        {7'b0000000, 3'b000}: op = alu_add;
                        {7'b0100000, 3'b000}: op = alu_sub;
                        {7'b0000000, 3'b001}: op = alu_sll;
                        {7'b0000000, 3'b010}: op = alu_slt;
                        {7'b0000000, 3'b011}: op = alu_sltu;
                        {7'b0000000, 3'b100}: op = alu_xor;
                        {7'b0000000, 3'b101}: op = alu_srl;
                        {7'b0100000, 3'b101}: op = alu_sra;
                        {7'b0000000, 3'b110}: op = alu_or;
                        {7'b0000000, 3'b111}: op = alu_and;
                        default: legal = 1'b0;
                        endcase
                end
                opc_op_imm: begin
                        legal = 1'b1;
                        use_imm = 1'b1;
                        case (funct3)
                        3'b000: op = alu_add;
                        3'b010: op = alu_slt;
                        3'b011: op = alu_sltu;
                        3'b100: op = alu_xor;
                        3'b110: op = alu_or;
                        3'b111: op = alu_and;
                        3'b001: begin
                                op = alu_sll;
                                imm = {{(xlen-5){1'b0}}, instr[24:20]}; // shamt
                                legal = (funct7 == 7'b0000000);
                        end
                        default: begin // 3'b101 is srli or srai
                                imm = {{(xlen-5){1'b0}}, instr[24:20]};
                                if (funct7 == 7'b0000000)
                                        op = alu_srl;
                                else if (funct7 == 7'b0100000)
                                        op = alu_sra;
                                else
                                        legal = 1'b0;
                        end
                        endcase
                end
                opc_lui: begin
                        legal = 1'b1;
                        use_imm = 1'b1;
                        op = alu_pass_b;
                        imm = {instr[31:12], 12'b0};
                end
                default: legal = 1'b0;
                endcase
        end

        assign ex.valid = instr_valid & legal;
        assign ex.illegal = instr_valid & ~legal;
        assign ex.op = op;
        assign ex.rd = instr[11:7];
        assign ex.rs1 = instr[19:15];
        assign ex.rs2 = instr[24:20];
        assign ex.imm = imm;
        assign ex.use_imm = use_imm;

        a_valid_illegal_excl: assert property (
                @(posedge clk) disable iff (reset) !(ex.valid && ex.illegal)
        );

endmodule

`default_nettype wire

/* source/apb_exec_regs.sv */
`default_nettype none

module apb_exec_regs import rv_exec_pkg::*; (
        input logic clk,
        input logic reset,

        input logic psel,
        input logic penable,
        input logic pwrite,
        input logic [apb_addr_w-1:0] paddr,
        input logic [xlen-1:0] pwdata,
        output logic [xlen-1:0] prdata,
        output logic pready,
        output logic pslverr,

        output logic [xlen-1:0] instr,
        output logic instr_valid,

        output reg_idx_t dbg_addr,
        output logic dbg_we,
        output logic [xlen-1:0] dbg_wdata,
        input logic [xlen-1:0] dbg_rdata,

        input logic alu_zero,
        exec_if.consumer ex
);

        logic access;
        logic sel_instr;
        logic sel_status;
        logic sel_retired;
        logic sel_window;
        logic mapped;
        logic wr_instr;
        logic clr_illegal;
        logic illegal_q;
        logic zero_q;
        logic [xlen-1:0] retired;
        logic [xlen-1:0] status;

        assign access = psel & penable;

        assign sel_instr = (paddr == addr_instr);
        assign sel_status = (paddr == addr_status);
        assign sel_retired = (paddr == addr_retired);
        assign sel_window = (paddr >= addr_reg_base) && (paddr <= addr_reg_last) &&
                            (paddr[1:0] == 2'b00);
        assign mapped = sel_instr | sel_status | sel_retired | sel_window;

        assign wr_instr = access & pwrite & sel_instr;
        assign clr_illegal = access & pwrite & sel_status & pwdata[status_illegal_bit];

        // window is aligned to its own size, so the index is a plain slice
        assign dbg_addr = paddr[2 +: $bits(reg_idx_t)];
        assign dbg_we = access & pwrite & sel_window;
        assign dbg_wdata = pwdata;

        assign pready = 1'b1; // no wait states

        // a status write without the clear bit is treated as a write to a read-only reg
        assign pslverr = access & (~mapped | (pwrite & sel_retired) |
                                   (pwrite & sel_status & ~pwdata[status_illegal_bit]));

        always_comb begin
                status = '0;
                status[status_illegal_bit] = illegal_q;
                status[status_zero_bit] = zero_q;
        end

        always_comb begin
                prdata = '0;
                if (sel_instr)
                        prdata = instr;
                else if (sel_status)
                        prdata = status;
                else if (sel_retired)
                        prdata = retired;
                else if (sel_window)
                        prdata = dbg_rdata;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        instr <= '0;
                        instr_valid <= 1'b0;
                        illegal_q <= 1'b0;
                        zero_q <= 1'b0;
                        retired <= '0;
                end else begin
                        instr_valid <= wr_instr; // one cycle after the access edge
                        if (wr_instr)
                                instr <= pwdata;
                        if (ex.illegal)
                                illegal_q <= 1'b1;
                        else if (clr_illegal)
                                illegal_q <= 1'b0;
                        if (ex.valid) begin
                                zero_q <= alu_zero;
                                retired <= retired + 1'b1;
                        end
                end
        end

        // access phase must follow a setup phase
        a_penable_after_setup: assert property (
                @(posedge clk) disable iff (reset) $rose(penable) |-> $past(psel)
        );

        a_instr_valid_pulse: assert property (
                @(posedge clk) disable iff (reset) instr_valid |=> !instr_valid
        );

endmodule

`default_nettype wire

/* source/rv_exec_top.sv */
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
        input logic clk,
        input logic reset,
        input logic psel,
        input logic penable,
        input logic pwrite,
        input logic [apb_addr_w-1:0] paddr,
        input logic [xlen-1:0] pwdata,
        output logic [xlen-1:0] prdata,
        output logic pready,
        output logic pslverr
);

        exec_if ex ();

        logic [xlen-1:0] instr;
        logic instr_valid;
        reg_idx_t dbg_addr;
        logic dbg_we;
        logic [xlen-1:0] dbg_wdata;
        logic [xlen-1:0] dbg_rdata;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] alu_result;
        logic alu_zero;

        apb_exec_regs i_regs (
                .clk, .reset,
                .psel, .penable, .pwrite, .paddr, .pwdata,
                .prdata, .pready, .pslverr,
                .instr, .instr_valid,
                .dbg_addr, .dbg_we, .dbg_wdata, .dbg_rdata,
                .alu_zero,
                .ex(ex.consumer)
        );

        rv_decoder i_dec (.clk, .reset, .instr, .instr_valid, .ex(ex.producer));

        reg_file i_rf (
                .clk, .reset, .ex(ex.consumer), .wdata(alu_result),
                .dbg_addr, .dbg_we, .dbg_wdata,
                .rs1_data, .rs2_data, .dbg_rdata
        );

        alu i_alu (.ex(ex.consumer), .rs1_data, .rs2_data, .result(alu_result), .zero(alu_zero));

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
        output logic clk
);

        localparam int half_period = 5; // 10 unit period

        initial clk = 1'b0;

        always #half_period clk = ~clk;

endmodule

`default_nettype wire

/* dv/rv_exec_tb.sv */
`default_nettype none

module rv_exec_tb import rv_exec_pkg::*; ();

        localparam int num_instr = 400;
        localparam int num_illegal = 40;
        localparam int timeout_cycles = num_instr * 12 * 4 + 800; // 20000

        logic clk;
        logic reset;
        logic psel;
        logic penable;
        logic pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [xlen-1:0] pwdata;
        logic [xlen-1:0] prdata;
        logic pready;
        logic pslverr;

        logic [31:0] lcg_state;
        int cycle_count = 0;
        int error_count = 0;
        logic [xlen-1:0] model_regs [num_regs];
        logic [xlen-1:0] model_retired;
        logic model_illegal;
        logic model_zero;

        tb_clock_gen i_clk (.clk);

        rv_exec_top i_dut (.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
                           .prdata, .pready, .pslverr);

        always @(posedge clk) begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
                        $display("Simulation FAILED");
                        $fatal(1);
                end
        end

        function automatic logic [31:0] rand_word();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state ^ (lcg_state >> 16); // fold upper bits down
        endfunction

        function automatic int rand_below(int n);
                return int'(rand_word() >> 1) % n;
        endfunction

        // corner values for compares and shifts
        function automatic logic [xlen-1:0] rand_operand();
                case (rand_below(8))
                0: return '0;
                1: return 32'd31;
                2: return 32'h8000_0000;
                3: return 32'hffff_ffff;
                default: return rand_word();
                endcase
        endfunction

        // rv32i op / op-imm result by funct3
        function automatic logic [xlen-1:0] op_result(input logic [2:0] f3, input logic alt,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
                case (f3)
                3'd0: return alt ? a - b : a + b;
                3'd1: return a << b[4:0];
                3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: return (a < b) ? 32'd1 : 32'd0;
                3'd4: return a ^ b;
                3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: return a | b;
                default: return a & b;
                endcase
        endfunction

        task automatic fail_run(input string msg);
                error_count++;
                $display("%s", msg);
                $display("Simulation FAILED");
                $fatal(1);
        endtask

        task automatic check_word(input string name, input logic [xlen-1:0] exp,
                                  input logic [xlen-1:0] act);
                if (act !== exp)
                        fail_run($sformatf("error: time %0t %s expected %h actual %h",
                                           $time, name, exp, act));
        endtask

        task automatic check_status(input logic [1:0] exp, input logic [1:0] act);
                if (act !== exp)
                        fail_run($sformatf("error: time %0t status expected %b actual %b",
                                           $time, exp, act));
        endtask

        task automatic check_count(input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
                if (act !== exp)
                        fail_run($sformatf("error: time %0t retired expected %0d actual %0d",
                                           $time, exp, act));
        endtask

        task automatic check_err(input logic [apb_addr_w-1:0] addr, input logic exp,
                                 input logic act);
                if (act !== exp)
                        fail_run($sformatf("error: time %0t pslverr at %h expected %b actual %b",
                                           $time, addr, exp, act));
        endtask

        // setup, access, then one idle cycle
        task automatic apb_transfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                                    input logic [xlen-1:0] wdata, input logic exp_err,
                                    output logic [xlen-1:0] rdata);
                @(posedge clk);
                #1;
                psel = 1'b1;
                pwrite = wr;
                paddr = addr;
                pwdata = wdata;
                @(posedge clk);
                #1;
                penable = 1'b1;
                #4; // mid access cycle
                if (pready !== 1'b1)
                        fail_run("pready was low during an APB access cycle");
                check_err(addr, exp_err, pslverr);
                rdata = prdata;
                @(posedge clk);
                #1;
                psel = 1'b0;
                penable = 1'b0;
        endtask

        task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] data,
                                 input logic exp_err);
                logic [xlen-1:0] unused_rdata;
                apb_transfer(1'b1, addr, data, exp_err, unused_rdata);
        endtask

        task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [xlen-1:0] data,
                                input logic exp_err);
                apb_transfer(1'b0, addr, '0, exp_err, data);
        endtask

        task automatic load_reg(input reg_idx_t n, input logic [xlen-1:0] value);
                apb_write(addr_reg_base + apb_addr_w'({n, 2'b00}), value, 1'b0);
                if (n != '0)
                        model_regs[n] = value;
        endtask

        task automatic verify_reg(input reg_idx_t n);
                logic [xlen-1:0] d;
                apb_read(addr_reg_base + apb_addr_w'({n, 2'b00}), d, 1'b0);
                check_word($sformatf("x%0d", n), model_regs[n], d);
        endtask

        task automatic verify_status();
                logic [xlen-1:0] d;
                apb_read(addr_status, d, 1'b0);
                check_status({model_zero, model_illegal},
                             {d[status_zero_bit], d[status_illegal_bit]});
                apb_read(addr_retired, d, 1'b0);
                check_count(model_retired, d);
        endtask

        task automatic run_legal();
                reg_idx_t rd;
                reg_idx_t rs1;
                reg_idx_t rs2;
                logic [2:0] f3;
                logic alt;
                logic [4:0] shamt;
                logic [11:0] imm12;
                logic [31:0] word;
                logic [xlen-1:0] res;
                int kind;
                rd = (rand_below(8) == 0) ? '0 : reg_idx_t'(rand_below(32));
                rs1 = reg_idx_t'(rand_below(32));
                rs2 = reg_idx_t'(rand_below(32));
                f3 = 3'(rand_below(8));
                alt = (rand_below(2) == 1);
                kind = rand_below(3);
                shamt = (rand_below(3) == 0) ? 5'd0 : 5'd31;
                if (rand_below(2) == 0)
                        shamt = 5'(rand_below(32));
                load_reg(rs1, rand_operand());
                load_reg(rs2, rand_operand());
                if (kind == 0) begin
                        alt = alt && (f3 == 3'd0 || f3 == 3'd5); // sub, sra
                        word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
                        res = op_result(f3, alt, model_regs[rs1], model_regs[rs2]);
                end else if (kind == 1) begin
                        alt = alt && (f3 == 3'd5); // srai
                        imm12 = 12'(rand_word());
                        if (f3 == 3'd1 || f3 == 3'd5)
                                imm12 = {1'b0, alt, 5'b0, shamt};
                        word = {imm12, rs1, f3, rd, opc_op_imm};
                        res = op_result(f3, alt, model_regs[rs1], {{20{imm12[11]}}, imm12});
                end else begin
                        word = {rand_word() & 32'hffff_f000};
                        res = word;
                        word = {word[31:12], rd, opc_lui};
                end
                apb_write(addr_instr, word, 1'b0);
                if (rd != '0)
                        model_regs[rd] = res;
                model_zero = (res == '0);
                model_retired = model_retired + 1;
                verify_reg(rd);
                verify_status();
        endtask

        task automatic run_illegal();
                logic [31:0] w;
                logic [31:0] word;
                logic [6:0] f7;
                logic [xlen-1:0] d;
                w = rand_word();
                f7 = w[31:25] | 7'h01; // neither 0000000 nor 0100000
                case (rand_below(3))
                0: begin
                        word = w;
                        if (w[6:0] == opc_op || w[6:0] == opc_op_imm || w[6:0] == opc_lui)
                                word[0] = 1'b0;
                end
                1: word = {f7, w[24:12], w[11:7], opc_op};
                default: word = {f7, w[24:15], w[12] ? 3'd5 : 3'd1, w[11:7], opc_op_imm};
                endcase
                apb_write(addr_instr, word, 1'b0);
                model_illegal = 1'b1;
                apb_read(addr_instr, d, 1'b0);
                check_word("instr", word, d);
                verify_reg(reg_idx_t'(word[11:7]));
                verify_status();
        endtask

        initial begin
                logic [xlen-1:0] d;
                lcg_state = 32'd40;
                reset = 1'b1;
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
                paddr = '0;
                pwdata = '0;
                for (int i = 0; i < num_regs; i++)
                        model_regs[i] = '0;
                model_retired = '0;
                model_illegal = 1'b0;
                model_zero = 1'b0;
                repeat (4) @(posedge clk);
                #1;
                reset = 1'b0;

                for (int i = 0; i < num_regs; i++)
                        verify_reg(reg_idx_t'(i));
                apb_read(addr_instr, d, 1'b0);
                check_word("instr", '0, d);
                verify_status();

                for (int i = 0; i < num_regs; i++)
                        load_reg(reg_idx_t'(i), rand_word()); // x0 write is dropped
                for (int i = 0; i < num_regs; i++)
                        verify_reg(reg_idx_t'(i));

                repeat (num_instr) run_legal();

                for (int i = 0; i < num_illegal; i++) begin
                        run_illegal();
                        if (i % 2 == 1) begin // sticky over two illegal words
                                apb_write(addr_status, 32'h1, 1'b0);
                                model_illegal = 1'b0;
                                verify_status();
                        end
                end

                apb_read(12'h00c, d, 1'b1);
                apb_write(12'h010, rand_word(), 1'b1);
                apb_read(12'h07c, d, 1'b1);
                apb_read(12'h082, d, 1'b1);
                apb_write(12'h100, rand_word(), 1'b1);
                apb_read(12'hffc, d, 1'b1);
                apb_write(addr_retired, rand_word(), 1'b1);
                apb_write(addr_status, 32'h2, 1'b1);
                verify_status();

                if (error_count == 0) begin
                        $display("Simulation PASSED");
                        $finish;
                end else begin
                        $display("Simulation FAILED");
                        $fatal(1);
                end
        end

endmodule

`default_nettype wire

/* rv_exec_top.f */
source/rv_exec_pkg.sv
source/exec_if.sv
source/alu.sv
source/reg_file.sv
source/rv_decoder.sv
source/apb_exec_regs.sv
source/rv_exec_top.sv
dv/tb_clock_gen.sv
dv/rv_exec_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module rv_exec_tb -f rv_exec_top.f -o rv_exec_sim
	./obj_dir/rv_exec_sim > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module rv_exec_top -f rv_exec_top.f

clean:
	rm -rf obj_dir sim.log
